// File: Bender.yml
package:
  name: spart_driver

sources:
  - target: any(rtl, test)
    files:
      - rtl/spart_driver_pkg.sv
      - rtl/databus_port.sv
      - rtl/dump_counters.sv
      - rtl/console_fsm.sv
      - rtl/spart_driver.sv
  - target: test
    files:
      - test/spart_bus_model.sv
      - test/tb_spart_driver.sv

// File: rtl/console_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module console_fsm (
	input  wire                               clk,
	input  wire                               rst,
	input  wire spart_driver_pkg::baud_cfg_t  br_cfg,
	input  wire                               rda,
	input  wire                               tbr,
	input  wire spart_driver_pkg::cmd_t       cmd,
	input  wire                               index_done,
	input  wire                               mem_done,
	input  wire                               mem_at_start,
	input  wire spart_driver_pkg::byte_t      index_char,
	input  wire spart_driver_pkg::byte_t      reg_char,
	input  wire spart_driver_pkg::byte_t      mem_char,
	output spart_driver_pkg::bus_req_t        bus_req,
	output spart_driver_pkg::dump_ctrl_t      dump_ctrl,
	output logic                              reg_re
);
	import spart_driver_pkg::*;

	console_state_t state;
	console_state_t next_state;
	// Divisor for the selected baud rate
	logic [15:0]    divisor;

	//////////////////////////////
	// Bus request helpers
	//////////////////////////////

	// Chip select off, bus released
	function automatic bus_req_t bus_idle();
		return '{drive: 1'b0, iocs: 1'b0, iorw: 1'b1, ioaddr: io_txrx, data: 8'h00};
	endfunction

	// Divisor byte into the baud generator
	function automatic bus_req_t db_write(io_addr_t addr, byte_t value);
		return '{drive: 1'b1, iocs: 1'b1, iorw: 1'b1, ioaddr: addr, data: value};
	endfunction

	// One character into the transmit buffer
	function automatic bus_req_t tx_write(byte_t ch);
		return '{drive: 1'b1, iocs: 1'b1, iorw: 1'b0, ioaddr: io_txrx, data: ch};
	endfunction

	// Receive read, SPART owns the bus
	function automatic bus_req_t rx_read();
		return '{drive: 1'b0, iocs: 1'b1, iorw: 1'b1, ioaddr: io_txrx, data: 8'h00};
	endfunction

	assign divisor = divisor_table[br_cfg];

	// State flop
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= init_low_db;
		end else begin
			state <= next_state;
		end
	end

	//////////////////////////////
	// Next state and outputs
	//////////////////////////////

	always_comb begin
		// Hold and stay idle unless a state says otherwise
		next_state = state;
		bus_req    = bus_idle();
		dump_ctrl  = '0;
		reg_re     = 1'b0;

		case (state)
			// Baud setup, one cycle each
			init_low_db: begin
				bus_req    = db_write(io_db_low, divisor[7:0]);
				next_state = init_high_db;
			end
			init_high_db: begin
				bus_req    = db_write(io_db_high, divisor[15:8]);
				next_state = receive_wait;
			end

			// Sit with chip select low until a byte arrives
			receive_wait: begin
				if (rda) begin
					bus_req = rx_read();
					case (cmd)
						cmd_dump: begin
							reg_re     = 1'b1;
							next_state = send_index;
						end
						cmd_dec: begin
							dump_ctrl.dec_index = 1'b1;
							next_state          = print_pc;
						end
						cmd_inc: begin
							dump_ctrl.inc_index = 1'b1;
							next_state          = print_pc;
						end
						default: begin
							// Anything else is dropped
							next_state = receive_wait;
						end
					endcase
				end
			end

			// Register line, index digit first
			send_index: begin
				reg_re = 1'b1;
				if (index_done) begin
					next_state = print_memory;
				end else if (tbr) begin
					bus_req    = tx_write(index_char);
					next_state = send_reg;
				end
			end

			// Register digit, index moves on the same edge
			send_reg: begin
				reg_re = 1'b1;
				if (tbr) begin
					bus_req             = tx_write(reg_char);
					dump_ctrl.inc_index = 1'b1;
					next_state          = next_line;
				end
			end

			// Separator after every entry
			// Registers left, or memory not yet begun, go back through send_index
			next_line: begin
				reg_re = 1'b1;
				if (tbr) begin
					bus_req = tx_write(char_space);
					if (!index_done || mem_at_start) begin
						next_state = send_index;
					end else begin
						next_state = print_memory;
					end
				end
			end

			// One memory byte per entry
			print_memory: begin
				if (mem_done) begin
					next_state = receive_wait;
				end else if (tbr) begin
					bus_req           = tx_write(mem_char);
					dump_ctrl.inc_mem = 1'b1;
					next_state        = next_line;
				end
			end

			// Echo a space after '1' or '2'
			print_pc: begin
				if (tbr) begin
					bus_req    = tx_write(char_space);
					next_state = receive_wait;
				end
			end

			default: begin
				next_state = init_low_db;
			end
		endcase
	end

	// Every character sent must be a known value
	// Register and memory data arrive from outside
	tx_data_chk: assert property (@(posedge clk) disable iff (rst)
		(bus_req.drive && !bus_req.iorw && bus_req.ioaddr == io_txrx)
		|-> !$isunknown(bus_req.data))
		else $error("console_fsm: transmit write with unknown data");

endmodule

`default_nettype wire

// File: rtl/databus_port.sv
`timescale 1ns/1ps
`default_nettype none

module databus_port (
	input  wire spart_driver_pkg::bus_req_t bus_req,
	inout  wire spart_driver_pkg::byte_t    databus,
	output logic                            iocs,
	output logic                            iorw,
	output spart_driver_pkg::io_addr_t      ioaddr,
	output spart_driver_pkg::cmd_t          cmd
);
	import spart_driver_pkg::*;

	// Tristate toward the SPART
	// Released whenever the FSM is not writing
	assign databus = bus_req.drive ? bus_req.data : 'z;

	// Strobes go straight to the SPART
	assign iocs   = bus_req.iocs;
	assign iorw   = bus_req.iorw;
	assign ioaddr = bus_req.ioaddr;

	//////////////////////////////
	// Command decode
	//////////////////////////////

	// Classify whatever sits on the bus
	// Only meaningful in the receive read cycle
	always_comb begin
		case (databus)
			char_enter: begin
				cmd = cmd_dump;
			end
			char_dec: begin
				cmd = cmd_dec;
			end
			char_inc: begin
				cmd = cmd_inc;
			end
			default: begin
				cmd = cmd_none;
			end
		endcase
	end

	// The SPART drives the bus while its receive register is read
	// so the driver must stay off it then
	bus_dir_chk: assert final (!(bus_req.drive && bus_req.iorw && bus_req.ioaddr == io_txrx))
		else $error("databus_port: bus driven during a receive read");

endmodule

`default_nettype wire

// File: rtl/dump_counters.sv
`timescale 1ns/1ps
`default_nettype none

module dump_counters #(
	parameter int reg_dump_len = 10,
	parameter int mem_dump_len = 10,
	parameter int addr_width   = 5
) (
	input  wire                               clk,
	input  wire                               rst,
	input  wire spart_driver_pkg::dump_ctrl_t dump_ctrl,
	input  wire spart_driver_pkg::word_t      reg_data,
	input  wire spart_driver_pkg::word_t      mem_data,
	output logic [addr_width-1:0]             reg_addr,
	output logic [addr_width-1:0]             mem_addr,
	output logic                              index_done,
	output logic                              mem_done,
	output logic                              mem_at_start,
	output spart_driver_pkg::byte_t           index_char,
	output spart_driver_pkg::byte_t           reg_char,
	output spart_driver_pkg::byte_t           mem_char
);
	import spart_driver_pkg::*;

	// Register index, wraps both ways
	logic [7:0]            reg_index;
	// Memory pointer, only reset brings it back
	logic [addr_width-1:0] mem_ptr;

	//////////////////////////////
	// Counters
	//////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			reg_index <= '0;
		end else if (dump_ctrl.inc_index) begin
			reg_index <= reg_index + 8'd1;
		end else if (dump_ctrl.dec_index) begin
			reg_index <= reg_index - 8'd1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mem_ptr <= '0;
		end else if (dump_ctrl.inc_mem) begin
			mem_ptr <= mem_ptr + 1'b1;
		end
	end

	// Read addresses
	assign reg_addr = reg_index[addr_width-1:0];
	assign mem_addr = mem_ptr;

	// Limit flags, compared at full width
	assign index_done   = 32'(reg_index) >= 32'(reg_dump_len);
	assign mem_done     = 32'(mem_ptr) >= 32'(mem_dump_len);
	assign mem_at_start = (mem_ptr == '0);

	//////////////////////////////
	// Printable characters
	//////////////////////////////

	// Single digit view, sum truncated to a byte
	assign index_char = reg_index + ascii_zero;
	assign reg_char   = reg_data[7:0] + ascii_zero;
	assign mem_char   = mem_data[7:0] + ascii_zero;

	// Index steps one way per cycle
	idx_dir_chk: assert property (@(posedge clk) disable iff (rst)
		!(dump_ctrl.inc_index && dump_ctrl.dec_index))
		else $error("dump_counters: index stepped both ways");

	// FSM stops advancing the pointer at the dump length
	mem_stop_chk: assert property (@(posedge clk) disable iff (rst)
		mem_done |=> $stable(mem_ptr))
		else $error("dump_counters: pointer moved past the dump length");

endmodule

`default_nettype wire

// File: rtl/spart_driver.sv
`timescale 1ns/1ps
`default_nettype none

module spart_driver #(
	parameter int reg_dump_len = 10,
	parameter int mem_dump_len = 10,
	parameter int addr_width   = 5
) (
	input  wire                               clk,
	input  wire                               rst,
	input  wire spart_driver_pkg::baud_cfg_t  br_cfg,
	output wire                               iocs,
	output wire                               iorw,
	output spart_driver_pkg::io_addr_t        ioaddr,
	inout  wire spart_driver_pkg::byte_t      databus,
	input  wire                               rda,
	input  wire                               tbr,
	output wire                               reg_re,
	output wire [addr_width-1:0]              reg_addr,
	input  wire spart_driver_pkg::word_t      reg_data,
	output wire [addr_width-1:0]              mem_addr,
	input  wire spart_driver_pkg::word_t      mem_data
);
	import spart_driver_pkg::*;

	//////////////////////////////
	// FSM links
	//////////////////////////////

	// FSM to bus port and back
	bus_req_t   bus_req;
	cmd_t       cmd;

	// FSM to counters and back
	dump_ctrl_t dump_ctrl;
	logic       index_done;
	logic       mem_done;
	logic       mem_at_start;
	byte_t      index_char;
	byte_t      reg_char;
	byte_t      mem_char;

	// Bus side
	databus_port u_port (
		.bus_req (bus_req),
		.databus (databus),
		.iocs    (iocs),
		.iorw    (iorw),
		.ioaddr  (ioaddr),
		.cmd     (cmd)
	);

	// Index and pointer for the dump
	dump_counters #(
		.reg_dump_len (reg_dump_len),
		.mem_dump_len (mem_dump_len),
		.addr_width   (addr_width)
	) u_counters (
		.clk          (clk),
		.rst          (rst),
		.dump_ctrl    (dump_ctrl),
		.reg_data     (reg_data),
		.mem_data     (mem_data),
		.reg_addr     (reg_addr),
		.mem_addr     (mem_addr),
		.index_done   (index_done),
		.mem_done     (mem_done),
		.mem_at_start (mem_at_start),
		.index_char   (index_char),
		.reg_char     (reg_char),
		.mem_char     (mem_char)
	);

	// Sequencer
	console_fsm u_fsm (
		.clk          (clk),
		.rst          (rst),
		.br_cfg       (br_cfg),
		.rda          (rda),
		.tbr          (tbr),
		.cmd          (cmd),
		.index_done   (index_done),
		.mem_done     (mem_done),
		.mem_at_start (mem_at_start),
		.index_char   (index_char),
		.reg_char     (reg_char),
		.mem_char     (mem_char),
		.bus_req      (bus_req),
		.dump_ctrl    (dump_ctrl),
		.reg_re       (reg_re)
	);

endmodule

`default_nettype wire

// File: rtl/spart_driver_pkg.sv
`default_nettype none

package spart_driver_pkg;

	//////////////////////////////
	// Data types
	//////////////////////////////

	// One byte on the SPART bus
	typedef logic [7:0] byte_t;

	// Register file and data memory word
	typedef logic [31:0] word_t;

	//////////////////////////////
	// Enums
	//////////////////////////////

	// Console FSM states
	// Slot 6 stays unused
	typedef enum logic [3:0] {
		init_low_db  = 4'h0,
		init_high_db = 4'h1,
		receive_wait = 4'h2,
		send_index   = 4'h3,
		send_reg     = 4'h4,
		print_memory = 4'h5,
		next_line    = 4'h7,
		print_pc     = 4'h8
	} console_state_t;

	// SPART register select
	typedef enum logic [1:0] {
		io_txrx    = 2'd0,
		io_status  = 2'd1,
		io_db_low  = 2'd2,
		io_db_high = 2'd3
	} io_addr_t;

	// Baud selection from the board switches
	typedef enum logic [1:0] {
		baud_4800  = 2'd0,
		baud_9600  = 2'd1,
		baud_19200 = 2'd2,
		baud_38400 = 2'd3
	} baud_cfg_t;

	// Console command decoded from a received byte
	typedef enum logic [1:0] {
		cmd_none = 2'd0,
		cmd_dump = 2'd1,
		cmd_dec  = 2'd2,
		cmd_inc  = 2'd3
	} cmd_t;

	//////////////////////////////
	// Structs
	//////////////////////////////

	// Bus request from the FSM to the tristate port
	typedef struct packed {
		logic     drive;
		logic     iocs;
		logic     iorw;
		io_addr_t ioaddr;
		byte_t    data;
	} bus_req_t;

	// Counter strobes from the FSM
	typedef struct packed {
		logic inc_index;
		logic dec_index;
		logic inc_mem;
	} dump_ctrl_t;

	//////////////////////////////
	// Constants
	//////////////////////////////

	// Baud divisors, low byte goes out first
	localparam logic [15:0] divisor_table [4] = '{16'h12C0, 16'h2580, 16'h4B00, 16'h9600};

	// Console characters
	localparam byte_t char_enter = 8'h0D;
	localparam byte_t char_dec   = 8'h31;
	localparam byte_t char_inc   = 8'h32;
	localparam byte_t char_space = 8'h20;

	// Offset that turns a small value into a digit
	localparam byte_t ascii_zero = 8'h30;

endpackage

`default_nettype wire

// File: spart_driver.f
rtl/spart_driver_pkg.sv
rtl/databus_port.sv
rtl/dump_counters.sv
rtl/console_fsm.sv
rtl/spart_driver.sv
test/spart_bus_model.sv
test/tb_spart_driver.sv

// File: test/spart_bus_model.sv
`timescale 1ns/1ps
`default_nettype none

module spart_bus_model #(
	parameter int addr_width = 5
) (
	input  wire                              clk,
	input  wire                              rst,
	input  wire                              iocs,
	input  wire                              iorw,
	input  wire spart_driver_pkg::io_addr_t  ioaddr,
	inout  wire spart_driver_pkg::byte_t     databus,
	output logic                             rda,
	output logic                             tbr,
	input  wire [addr_width-1:0]             reg_addr,
	output spart_driver_pkg::word_t          reg_data,
	input  wire [addr_width-1:0]             mem_addr,
	output spart_driver_pkg::word_t          mem_data,
	input  wire                              rx_strobe,
	input  wire spart_driver_pkg::byte_t     rx_char,
	input  wire                              stall_en
);
	import spart_driver_pkg::*;

	// Write logs, drained by the testbench
	byte_t    tx_log[$];
	io_addr_t db_addr_log[$];
	byte_t    db_data_log[$];
	// Character writes seen while tbr was low
	int       tbr_low_writes = 0;

	logic rx_read;
	logic tx_write;

	// Receive byte only sits on the bus during the read cycle
	assign rda      = rx_strobe;
	assign rx_read  = rda && iocs && iorw && ioaddr == io_txrx;
	assign tx_write = iocs && !iorw && ioaddr == io_txrx;
	assign databus  = rx_read ? rx_char : 'z;

	// Read ports, pattern covers the whole address
	assign reg_data = {{3{8'(reg_addr)}}, 8'(3 * reg_addr + 1)};
	assign mem_data = {{3{~8'(mem_addr)}}, 8'(mem_addr + 4)};

	//////////////////////////////
	// Write capture
	//////////////////////////////

	// Bus is settled mid cycle
	always @(negedge clk) begin
		if (!rst && iocs && iorw && (ioaddr == io_db_low || ioaddr == io_db_high)) begin
			db_addr_log.push_back(ioaddr);
			db_data_log.push_back(databus);
		end
		if (!rst && tx_write) begin
			tx_log.push_back(databus);
			if (!tbr) begin
				tbr_low_writes++;
			end
		end
	end

	// Transmit buffer busy for 0 to 3 cycles after each character
	initial begin
		int unsigned gap;
		// Seed the stall pattern
		gap = $urandom(2);
		tbr = 1'b1;
		forever begin
			@(negedge clk);
			if (!rst && tx_write) begin
				gap = stall_en ? $urandom % 4 : 0;
				@(posedge clk);
				#1;
				if (gap != 0) begin
					tbr = 1'b0;
					repeat (gap) @(posedge clk);
					#1;
					tbr = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: test/tb_spart_driver.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spart_driver;
	import spart_driver_pkg::*;

	localparam int reg_dump_len  = 10;
	localparam int mem_dump_len  = 10;
	localparam int addr_width    = 5;
	localparam int n_rows        = 20;
	// Worst idle tail after the last character is two cycles
	localparam int settle_cycles = 4;

	// One console step
	typedef struct packed {
		logic      do_reset;
		baud_cfg_t br;
		byte_t     ch;
		logic      stall;
	} row_t;

	localparam row_t cmd_table [n_rows] = '{
		// Full dump, then silent dump, '1', single line, junk
		'{1'b1, baud_4800, 8'h0D, 1'b0},
		'{1'b0, baud_4800, 8'h0D, 1'b0},
		'{1'b0, baud_4800, 8'h31, 1'b0},
		'{1'b0, baud_4800, 8'h0D, 1'b0},
		'{1'b0, baud_4800, 8'h41, 1'b0},
		// Index wraps below zero, memory only dump
		'{1'b1, baud_9600, 8'h31, 1'b0},
		'{1'b0, baud_9600, 8'h0D, 1'b0},
		'{1'b0, baud_9600, 8'h32, 1'b0},
		'{1'b0, baud_9600, 8'h32, 1'b0},
		'{1'b0, baud_9600, 8'h0D, 1'b0},
		'{1'b0, baud_9600, 8'h00, 1'b0},
		// Random tbr stalls
		'{1'b1, baud_19200, 8'h0D, 1'b1},
		'{1'b0, baud_19200, 8'h31, 1'b1},
		'{1'b0, baud_19200, 8'h0D, 1'b1},
		'{1'b1, baud_38400, 8'h32, 1'b1},
		'{1'b0, baud_38400, 8'h32, 1'b1},
		'{1'b0, baud_38400, 8'h31, 1'b1},
		'{1'b0, baud_38400, 8'h0D, 1'b1},
		'{1'b0, baud_38400, 8'h33, 1'b1},
		'{1'b0, baud_38400, 8'h0A, 1'b1}
	};

	logic                  clk;
	logic                  rst;
	baud_cfg_t             br_cfg;
	logic                  rx_strobe;
	byte_t                 rx_char;
	logic                  stall_en;
	wire                   iocs;
	wire                   iorw;
	wire io_addr_t         ioaddr;
	wire byte_t            databus;
	wire                   rda;
	wire                   tbr;
	wire                   reg_re;
	wire [addr_width-1:0]  reg_addr;
	wire word_t            reg_data;
	wire [addr_width-1:0]  mem_addr;
	wire word_t            mem_data;

	// Reference console state
	logic [7:0] model_index;
	int         model_ptr;
	byte_t      exp_q[$];
	// Expected reg_re per character write
	bit         re_exp_q[$];
	// reg_re seen with each character write
	bit         re_log[$];

	int checks      = 0;
	int errors      = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	spart_driver #(
		.reg_dump_len (reg_dump_len),
		.mem_dump_len (mem_dump_len),
		.addr_width   (addr_width)
	) u_dut (
		.clk      (clk),
		.rst      (rst),
		.br_cfg   (br_cfg),
		.iocs     (iocs),
		.iorw     (iorw),
		.ioaddr   (ioaddr),
		.databus  (databus),
		.rda      (rda),
		.tbr      (tbr),
		.reg_re   (reg_re),
		.reg_addr (reg_addr),
		.reg_data (reg_data),
		.mem_addr (mem_addr),
		.mem_data (mem_data)
	);

	spart_bus_model #(
		.addr_width (addr_width)
	) u_spart (
		.clk       (clk),
		.rst       (rst),
		.iocs      (iocs),
		.iorw      (iorw),
		.ioaddr    (ioaddr),
		.databus   (databus),
		.rda       (rda),
		.tbr       (tbr),
		.reg_addr  (reg_addr),
		.reg_data  (reg_data),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data),
		.rx_strobe (rx_strobe),
		.rx_char   (rx_char),
		.stall_en  (stall_en)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Hang guard
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: driver still busy after %0d cycles", cycle_count);
			$display("** FAIL **");
			$finish;
		end
	end

	// Read enable alongside each character, bus settled mid cycle
	always @(negedge clk) begin
		if (!rst && iocs && !iorw && ioaddr == io_txrx) begin
			re_log.push_back(reg_re);
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Value as an ASCII digit, wraps at a byte
	function automatic byte_t digit(input int value);
		return 8'(value + 'h30);
	endfunction

	task automatic model_clear();
		model_index = '0;
		model_ptr   = 0;
	endtask

	// Characters one received byte should produce
	task automatic predict(input byte_t ch);
		if (ch == 8'h0D) begin
			// Register triples from the current index
			while (model_index < reg_dump_len) begin
				exp_q.push_back(digit(model_index));
				exp_q.push_back(digit(3 * model_index + 1));
				exp_q.push_back(8'h20);
				// Whole register line keeps the read enable up
				repeat (3) begin
					re_exp_q.push_back(1'b1);
				end
				model_index++;
			end
			// Memory pointer only ever moves forward
			while (model_ptr < mem_dump_len) begin
				exp_q.push_back(digit(model_ptr + 4));
				exp_q.push_back(8'h20);
				// Memory byte without it, separator with it
				re_exp_q.push_back(1'b0);
				re_exp_q.push_back(1'b1);
				model_ptr++;
			end
		end else if (ch == 8'h31) begin
			model_index--;
			exp_q.push_back(8'h20);
			re_exp_q.push_back(1'b0);
		end else if (ch == 8'h32) begin
			model_index++;
			exp_q.push_back(8'h20);
			re_exp_q.push_back(1'b0);
		end
	endtask

	//////////////////////////////
	// Checks and drivers
	//////////////////////////////

	task automatic check_value(input string name, input int unsigned expected,
		input int unsigned actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERR time %0t %s expected 0x%0h actual 0x%0h", $time, name, expected,
				actual);
		end
	endtask

	task automatic apply_reset(input baud_cfg_t br);
		@(posedge clk);
		#1;
		rst    = 1'b1;
		br_cfg = br;
		u_spart.tx_log.delete();
		u_spart.db_addr_log.delete();
		u_spart.db_data_log.delete();
		re_log.delete();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		model_clear();
	endtask

	// Divisor equals the baud rate, low byte first
	task automatic check_divisor(input baud_cfg_t br);
		int unsigned div;
		div = 4800 << br;
		while (u_spart.db_data_log.size() < 2) begin
			@(posedge clk);
		end
		check_value("ioaddr", 2, u_spart.db_addr_log[0]);
		check_value("databus", div[7:0], u_spart.db_data_log[0]);
		check_value("ioaddr", 3, u_spart.db_addr_log[1]);
		check_value("databus", div[15:8], u_spart.db_data_log[1]);
		u_spart.db_addr_log.delete();
		u_spart.db_data_log.delete();
	endtask

	// One cycle of rda with the byte on the bus
	task automatic send_byte(input byte_t ch);
		@(posedge clk);
		#1;
		rx_strobe = 1'b1;
		rx_char   = ch;
		// Only the enter cycle reads the register port
		@(negedge clk);
		check_value("reg_re", (ch == 8'h0D), reg_re);
		@(posedge clk);
		#1;
		rx_strobe = 1'b0;
	endtask

	task automatic run_row(input row_t row);
		int n;
		int i;
		if (row.do_reset) begin
			apply_reset(row.br);
			check_divisor(row.br);
		end
		stall_en = row.stall;
		exp_q.delete();
		re_exp_q.delete();
		predict(row.ch);
		send_byte(row.ch);
		while (u_spart.tx_log.size() < exp_q.size()) begin
			@(posedge clk);
		end
		repeat (settle_cycles) @(posedge clk);
		check_value("tx count", exp_q.size(), u_spart.tx_log.size());
		n = (exp_q.size() < u_spart.tx_log.size()) ? exp_q.size() : u_spart.tx_log.size();
		for (i = 0; i < n; i++) begin
			check_value("databus", exp_q[i], u_spart.tx_log[i]);
			check_value("reg_re", re_exp_q[i], re_log[i]);
		end
		// Index after the step, wrap shows up here
		check_value("reg_addr", model_index[addr_width-1:0], reg_addr);
		check_value("index_char", digit(model_index), u_dut.index_char);
		check_value("divisor writes", 0, u_spart.db_data_log.size());
		// Idle in the wait state
		check_value("reg_re", 0, reg_re);
		check_value("iocs", 0, iocs);
		u_spart.tx_log.delete();
		re_log.delete();
	endtask

	initial begin
		int i;
		int total;
		rst       = 1'b1;
		br_cfg    = baud_4800;
		rx_strobe = 1'b0;
		rx_char   = 8'h00;
		stall_en  = 1'b0;

		// Budget from the expected write count
		total = 0;
		for (i = 0; i < n_rows; i++) begin
			if (cmd_table[i].do_reset) begin
				model_clear();
				total += 2;
			end
			exp_q.delete();
			predict(cmd_table[i].ch);
			total += exp_q.size();
		end
		cycle_limit = total * 8 + 200;

		for (i = 0; i < n_rows; i++) begin
			run_row(cmd_table[i]);
		end

		check_value("tbr low writes", 0, u_spart.tbr_low_writes);
		$display("Checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire
